// ==== design/dlx_flit_pkg.sv ====
/* Flit layout for the short-flit receive stage
   Field offsets inside a lane are lane-relative, flit offsets are absolute */
`default_nettype none

package dlx_flit_pkg;

  // Flit geometry
  parameter int unsigned FLIT_W    = 512;
  parameter int unsigned LANE_W    = 128;
  parameter int unsigned NUM_LANES = 4;

  typedef logic [FLIT_W-1:0]    flit_t;      // Whole 4-lane flit
  typedef logic [LANE_W-1:0]    lane_t;      // One lane, also one short flit
  typedef logic [NUM_LANES-1:0] lane_mask_t; // One bit per lane

  // DL content fields
  typedef logic [3:0] run_length_t; // Run length field and data flit counter
  typedef logic [4:0] ack_cnt_t;    // ACK count
  typedef logic [1:0] recal_t;      // Recalibration status

  // Run length of a long control flit, lives in lane 3
  parameter int unsigned RL_LSB = 448;

  // Base of lane 3, where the long control fields sit
  parameter int unsigned LANE3_BASE = 384;

  // Lane-relative positions
  parameter int unsigned SFN_BIT   = 82; // Short flit next
  parameter int unsigned RECAL_LSB = 85; // Recal status, bits 86:85
  parameter int unsigned ACK_LSB   = 87; // ACK count, bits 91:87

  // Run lengths 1..9 announce data flits, anything else means none follow
  parameter int unsigned MAX_DATA_RL = 9;

endpackage : dlx_flit_pkg

`default_nettype wire

// ==== design/dlx_rx_ctl_pkg.sv ====
/* Receive control definitions: tracker mode and short flit CRC constants
   CRC is CRC-16 over a full 128-bit lane, MSB first, zero residue passes */
`default_nettype none

package dlx_rx_ctl_pkg;

  // Tracker mode
  typedef enum logic {
    MODE_LONG  = 1'b0, // Normal 512-bit flits
    MODE_SHORT = 1'b1  // Next valid flit holds four short idles
  } rx_mode_e;

  typedef logic [15:0] crc16_t;

  parameter crc16_t CRC16_POLY_DEFAULT = 16'h1021; // x^16 + x^12 + x^5 + 1
  parameter crc16_t CRC16_INIT         = 16'h0000; // Register seed

endpackage : dlx_rx_ctl_pkg

`default_nettype wire

// ==== design/lane_crc_check.sv ====
/* CRC-16 residue over one 128-bit lane, purely combinational
   Lane includes its own check bits, so a good lane leaves a zero residue */
`timescale 1ns/1ps
`default_nettype none

module lane_crc_check
  import dlx_flit_pkg::*, dlx_rx_ctl_pkg::*;
#(
  parameter crc16_t CRC_POLY = CRC16_POLY_DEFAULT
) (
  input  lane_t lane,
  output logic  crc_fail
);

  crc16_t residue;

  // Serial LFSR unrolled, MSB of the lane enters first
  always_comb begin
    logic feedback;
    residue = CRC16_INIT;
    for (int i = LANE_W - 1; i >= 0; i--) begin
      feedback = residue[15] ^ lane[i];
      residue  = {residue[14:0], 1'b0};
      if (feedback) begin
        residue = residue ^ CRC_POLY;
      end
    end
  end

  assign crc_fail = |residue;  // Any leftover bit is a bad lane

endmodule : lane_crc_check

`default_nettype wire

// ==== design/flit_tracker.sv ====
/* Captures incoming flits and follows the control flit run length
   Strobes are combinational from the captured flit and are valid one cycle after capture
   No back-pressure, every valid flit is classified */
`timescale 1ns/1ps
`default_nettype none

module flit_tracker
  import dlx_flit_pkg::*, dlx_rx_ctl_pkg::*;
(
  input  wire   rx_clk_in,
  input  wire   reset,
  input  wire   valid_in,
  input  flit_t flit_in,
  output flit_t flit_q,
  output logic  pass_flit,
  output logic  check_short
);

  logic        valid_q;        // Captured valid strobe
  rx_mode_e    mode_q;         // Long or short flit expected
  rx_mode_e    mode_nxt;
  run_length_t rl_cnt_q;       // Data flits still to come
  run_length_t rl_cnt_nxt;
  run_length_t rl_field;       // Run length of a control flit
  logic        rl_has_data;    // Run length in 1..MAX_DATA_RL
  logic        sfn_l3;         // Short flit next, lane 3
  logic        is_long;
  logic        is_ctl;

  // Payload capture, holds when no valid
  always_ff @(posedge rx_clk_in) begin
    if (valid_in) begin
      flit_q <= flit_in;
    end
  end

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      valid_q  <= 1'b0;
      mode_q   <= MODE_LONG;
      rl_cnt_q <= '0;
    end else begin
      valid_q  <= valid_in;
      mode_q   <= mode_nxt;
      rl_cnt_q <= rl_cnt_nxt;
    end
  end

  // Field decode on the captured flit
  assign rl_field    = flit_q[RL_LSB +: $bits(run_length_t)];
  assign sfn_l3      = flit_q[LANE3_BASE + SFN_BIT];
  assign rl_has_data = (rl_field != '0) && (rl_field <= run_length_t'(MAX_DATA_RL));

  assign is_long = valid_q && (mode_q == MODE_LONG);
  assign is_ctl  = is_long && (rl_cnt_q == '0);  // Zero count, flit is control

  // Long flits go on, short flits are absorbed
  assign pass_flit   = is_long;
  assign check_short = valid_q && (mode_q == MODE_SHORT);

  always_comb begin
    mode_nxt   = mode_q;
    rl_cnt_nxt = rl_cnt_q;
    if (is_long && !is_ctl) begin
      rl_cnt_nxt = rl_cnt_q - 1'b1;  // Data flit
    end
    if (is_ctl) begin
      if (rl_has_data) begin
        rl_cnt_nxt = rl_field;       // Data flits follow
      end else if (sfn_l3) begin
        mode_nxt = MODE_SHORT;       // No data, short idles next
      end
    end
    // Short chain carries on only while lane 3 asks for more
    if (check_short && !sfn_l3) begin
      mode_nxt = MODE_LONG;
    end
  end

endmodule : flit_tracker

`default_nettype wire

// ==== design/short_flit_checker.sv ====
/* Checks the four short idles of a short flit and collects ACK and recal info
   Error is sticky until the next valid_out, force_pulse marks its first cycle
   ACK total lags the error and recal registers by one cycle */
`timescale 1ns/1ps
`default_nettype none

module short_flit_checker
  import dlx_flit_pkg::*, dlx_rx_ctl_pkg::*;
#(
  parameter crc16_t CRC_POLY = CRC16_POLY_DEFAULT
) (
  input  wire      rx_clk_in,
  input  wire      reset,
  input  flit_t    flit_q,
  input  wire      check_short,
  input  wire      valid_out,
  output logic     sf_crc_error,
  output ack_cnt_t sf_ack_cnt,
  output recal_t   sf_recal_status,
  output logic     force_pulse
);

  lane_t      lane [NUM_LANES];
  lane_mask_t crc_fail;        // Raw residue check per lane
  lane_mask_t lane_err;        // Failures of a real short flit
  lane_mask_t lane_ok;         // Passing lanes of a real short flit
  ack_cnt_t   ack_lane_q [NUM_LANES];
  ack_cnt_t   ack_sum;
  recal_t     recal_nxt;
  logic       err_q;
  logic       err_dly_q;       // Error one cycle back, for edge detect

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane[g] = flit_q[g*LANE_W +: LANE_W];

    lane_crc_check #(
      .CRC_POLY (CRC_POLY)
    ) u_crc (
      .lane     (lane[g]),
      .crc_fail (crc_fail[g])
    );
  end

  // Only a short flit cycle counts
  assign lane_err = crc_fail & {NUM_LANES{check_short}};
  assign lane_ok  = ~crc_fail & {NUM_LANES{check_short}};

  // Recal from the highest lane with an unbroken run of passes below it
  always_comb begin
    logic run_ok;
    run_ok    = 1'b1;
    recal_nxt = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      run_ok = run_ok & lane_ok[i];
      if (run_ok) begin
        recal_nxt = lane[i][RECAL_LSB +: $bits(recal_t)];
      end
    end
  end

  // Modulo 32 total of the staged per-lane counts
  always_comb begin
    ack_sum = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      ack_sum = ack_sum + ack_lane_q[i];
    end
  end

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        ack_lane_q[i] <= '0;
      end
      sf_ack_cnt      <= '0;
      sf_recal_status <= '0;
      err_q           <= 1'b0;
      err_dly_q       <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        // Failing lane contributes nothing
        ack_lane_q[i] <= lane_ok[i] ? lane[i][ACK_LSB +: $bits(ack_cnt_t)] : '0;
      end
      sf_ack_cnt      <= ack_sum;  // Second stage
      sf_recal_status <= recal_nxt;
      err_q           <= (|lane_err) | (err_q & ~valid_out);  // New failure wins over clear
      err_dly_q       <= err_q;
    end
  end

  assign sf_crc_error = err_q;
  assign force_pulse  = err_q & ~err_dly_q;  // First error cycle only

endmodule : short_flit_checker

`default_nettype wire

// ==== design/flit_output_stage.sv ====
/* Output register for long flits plus valid and forced-valid strobes
   flit_out holds its last long flit across short flits and forced pulses */
`timescale 1ns/1ps
`default_nettype none

module flit_output_stage
  import dlx_flit_pkg::*;
(
  input  wire   rx_clk_in,
  input  wire   reset,
  input  flit_t flit_q,
  input  wire   pass_flit,
  input  wire   force_pulse,
  output flit_t flit_out,
  output logic  valid_out,
  output logic  forced_valid_out
);

  // Data register, loads only for long flits
  always_ff @(posedge rx_clk_in) begin
    if (pass_flit) begin
      flit_out <= flit_q;
    end
  end

  always_ff @(posedge rx_clk_in) begin
    if (reset) begin
      valid_out        <= 1'b0;
      forced_valid_out <= 1'b0;
    end else begin
      valid_out        <= pass_flit | force_pulse;
      // A real flit in the same cycle already carries the valid
      forced_valid_out <= force_pulse & ~pass_flit;
    end
  end

endmodule : flit_output_stage

`default_nettype wire

// ==== design/rx_short_flit_top.sv ====
/* Short-flit receive stage: long flits out at two cycles, short flits absorbed
   Plain strobes only, no handshake or back-pressure */
`timescale 1ns/1ps
`default_nettype none

module rx_short_flit_top
  import dlx_flit_pkg::*, dlx_rx_ctl_pkg::*;
#(
  parameter crc16_t CRC_POLY = CRC16_POLY_DEFAULT  // Short flit CRC polynomial
) (
  input  wire      rx_clk_in,
  input  wire      reset,
  input  wire      valid_in,
  input  flit_t    flit_in,
  output logic     valid_out,
  output logic     forced_valid_out,
  output flit_t    flit_out,
  output logic     sf_crc_error,
  output ack_cnt_t sf_ack_cnt,
  output recal_t   sf_recal_status
);

  flit_t flit_q;       // Captured flit
  logic  pass_flit;    // Long flit strobe
  logic  check_short;  // Short flit strobe
  logic  force_pulse;  // First cycle of a CRC error

  flit_tracker u_tracker (
    .rx_clk_in   (rx_clk_in),
    .reset       (reset),
    .valid_in    (valid_in),
    .flit_in     (flit_in),
    .flit_q      (flit_q),
    .pass_flit   (pass_flit),
    .check_short (check_short)
  );

  short_flit_checker #(
    .CRC_POLY (CRC_POLY)
  ) u_checker (
    .rx_clk_in       (rx_clk_in),
    .reset           (reset),
    .flit_q          (flit_q),
    .check_short     (check_short),
    .valid_out       (valid_out),     // Clears the sticky error
    .sf_crc_error    (sf_crc_error),
    .sf_ack_cnt      (sf_ack_cnt),
    .sf_recal_status (sf_recal_status),
    .force_pulse     (force_pulse)
  );

  flit_output_stage u_out (
    .rx_clk_in        (rx_clk_in),
    .reset            (reset),
    .flit_q           (flit_q),
    .pass_flit        (pass_flit),
    .force_pulse      (force_pulse),
    .flit_out         (flit_out),
    .valid_out        (valid_out),
    .forced_valid_out (forced_valid_out)
  );

endmodule : rx_short_flit_top

`default_nettype wire

// ==== tests/rx_short_flit_asserts.sv ====
/* Timing checks for rx_short_flit_top, attached by bind
   All checks except the reset one are off while reset is high */
`timescale 1ns/1ps
`default_nettype none

module rx_short_flit_asserts
  import dlx_flit_pkg::*;
(
  input wire           rx_clk_in,
  input wire           reset,
  input wire           valid_out,
  input wire           forced_valid_out,
  input wire           sf_crc_error,
  input wire ack_cnt_t sf_ack_cnt,
  input wire recal_t   sf_recal_status
);

  int unsigned fail_cnt = 0;  // Number of failed checks

  // Everything idle in the cycle after a reset edge
  a_reset_idle: assert property (@(posedge rx_clk_in)
      reset |=> (!valid_out && !forced_valid_out && !sf_crc_error &&
                 sf_ack_cnt == '0 && sf_recal_status == '0))
    else begin
      $error("outputs not zero after reset");
      fail_cnt++;
    end

  // A forced pulse is also a valid
  a_forced_has_valid: assert property (@(posedge rx_clk_in) disable iff (reset)
      forced_valid_out |-> valid_out)
    else begin
      $error("forced_valid_out high without valid_out");
      fail_cnt++;
    end

  a_error_forces: assert property (@(posedge rx_clk_in) disable iff (reset)
      $rose(sf_crc_error) |=> forced_valid_out)  // One pulse per new error
    else begin
      $error("no forced_valid_out after sf_crc_error rose");
      fail_cnt++;
    end

  a_forced_single: assert property (@(posedge rx_clk_in) disable iff (reset)
      forced_valid_out |=> !forced_valid_out)
    else begin
      $error("forced_valid_out high for two cycles");
      fail_cnt++;
    end

endmodule : rx_short_flit_asserts

bind rx_short_flit_top rx_short_flit_asserts u_asserts (
  .rx_clk_in        (rx_clk_in),
  .reset            (reset),
  .valid_out        (valid_out),
  .forced_valid_out (forced_valid_out),
  .sf_crc_error     (sf_crc_error),
  .sf_ack_cnt       (sf_ack_cnt),
  .sf_recal_status  (sf_recal_status)
);

`default_nettype wire

// ==== tests/tb_rx_short_flit.sv ====
/* Testbench for rx_short_flit_top. Inputs change on the falling edge, outputs are checked
   at the next falling edge against a cycle model of the flit rules
   Model times count from the edge that samples valid_in, results show one or two cycles later */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_short_flit
  import dlx_flit_pkg::*, dlx_rx_ctl_pkg::*;
();

  logic       rx_clk_in = 1'b0;
  logic       reset;
  logic       valid_in;
  flit_t      flit_in;
  logic       valid_out;
  logic       forced_valid_out;
  flit_t      flit_out;
  logic       sf_crc_error;
  ack_cnt_t   sf_ack_cnt;
  recal_t     sf_recal_status;

  int         cyc = 0;             // Rising edges so far
  bit         mon_on = 1'b0;
  string      test_name = "reset";
  bit         md_short = 1'b0;     // Model of the tracker mode
  int         rl_left = 0;         // Data flits still owed by the last control flit
  int         last_sched = 0;      // Latest cycle with a scheduled result
  bit         err_prev = 1'b0;
  bit         vout_prev = 1'b0;
  bit         flit_known = 1'b0;   // flit_out is X until the first long flit
  flit_t      flit_hold;
  // Expected results, ring indexed by cycle
  bit         exp_long [8];
  flit_t      exp_flit [8];
  bit         exp_fail [8];
  bit         exp_force [8];
  ack_cnt_t   exp_ack [8];
  recal_t     exp_recal [8];

  rx_short_flit_top DUT (
    .rx_clk_in        (rx_clk_in),
    .reset            (reset),
    .valid_in         (valid_in),
    .flit_in          (flit_in),
    .valid_out        (valid_out),
    .forced_valid_out (forced_valid_out),
    .flit_out         (flit_out),
    .sf_crc_error     (sf_crc_error),
    .sf_ack_cnt       (sf_ack_cnt),
    .sf_recal_status  (sf_recal_status)
  );

  always #20 rx_clk_in = ~rx_clk_in;  // 40 ns period

  always @(posedge rx_clk_in) cyc <= cyc + 1;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_value(string what, logic [FLIT_W-1:0] exp, logic [FLIT_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act));
    end
  endtask

  function automatic lane_t rand128();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // CCITT remainder of the 112 message bits, so the whole lane divides evenly
  function automatic logic [15:0] crc_ccitt(logic [111:0] msg);
    logic [15:0] crc;
    crc = 16'h0000;
    for (int i = 111; i >= 0; i--) begin
      if (crc[15] ^ msg[i]) begin
        crc = {crc[14:0], 1'b0} ^ CRC16_POLY_DEFAULT;
      end else begin
        crc = {crc[14:0], 1'b0};
      end
    end
    return crc;
  endfunction

  function automatic lane_t good_lane(ack_cnt_t ack, recal_t rc, bit sfn);
    lane_t l;
    l = rand128();
    l[ACK_LSB +: $bits(ack_cnt_t)] = ack;
    l[RECAL_LSB +: $bits(recal_t)] = rc;
    l[SFN_BIT] = sfn;
    l[15:0] = crc_ccitt(l[127:16]);  // Check bits at the bottom
    return l;
  endfunction

  function automatic flit_t long_flit(bit sfn);
    flit_t f;
    f = {rand128(), rand128(), rand128(), rand128()};
    f[LANE3_BASE + SFN_BIT] = sfn;
    return f;
  endfunction

  function automatic flit_t control_flit(run_length_t rl, bit sfn);
    flit_t f;
    f = long_flit(sfn);
    f[RL_LSB +: $bits(run_length_t)] = rl;
    return f;
  endfunction

  // Four short idles, lane bad gets one flipped bit (none when negative)
  // With a bad lane every lane has its own recal and the bad lane a nonzero ACK
  function automatic flit_t short_flit(bit sfn3, int bad);
    flit_t    f;
    lane_t    l;
    int       k;
    ack_cnt_t ack;
    recal_t   rc;
    for (int i = 0; i < NUM_LANES; i++) begin
      ack = ack_cnt_t'($urandom);
      rc  = recal_t'($urandom);
      if (bad >= 0) begin
        rc = recal_t'(i);
        if (i == bad) begin
          ack = ack | 5'd1;
        end
      end
      l = good_lane(ack, rc, (i == 3) ? sfn3 : 1'b0);
      if (i == bad) begin
        k = $urandom_range(LANE_W - 1);
        l[k] = ~l[k];  // Single bit error, CRC-16 always sees it
      end
      f[i*LANE_W +: LANE_W] = l;
    end
    return f;
  endfunction

  function automatic lane_mask_t lane_mask(int bad);
    lane_mask_t m;
    m = '1;
    if (bad >= 0) begin
      m[bad] = 1'b0;
    end
    return m;
  endfunction

  // Drive one valid flit and schedule what the rules say it produces
  task automatic send_flit(flit_t f, lane_mask_t ok);
    int          e;
    int          ff;
    run_length_t rl;
    ack_cnt_t    sum;
    @(negedge rx_clk_in);
    valid_in = 1'b1;
    flit_in  = f;
    e = cyc + 1;  // Sampling edge
    if (!md_short) begin
      exp_long[(e + 1) & 7] = 1'b1;  // Long flit shows one cycle after capture
      exp_flit[(e + 1) & 7] = f;
      last_sched = e + 1;
      rl = f[RL_LSB +: $bits(run_length_t)];
      if (rl_left > 0) begin
        rl_left--;
      end else if (rl >= 1 && rl <= MAX_DATA_RL) begin
        rl_left = rl;
      end else if (f[LANE3_BASE + SFN_BIT]) begin
        md_short = 1'b1;
      end
    end else begin
      ff  = NUM_LANES;  // First failing lane
      sum = '0;
      for (int i = NUM_LANES - 1; i >= 0; i--) begin
        if (!ok[i]) begin
          ff = i;
        end else begin
          sum = sum + f[i*LANE_W + ACK_LSB +: $bits(ack_cnt_t)];
        end
      end
      // Recal from the lane just below the first failure
      exp_recal[(e + 1) & 7] = (ff == 0) ? '0 : f[(ff-1)*LANE_W + RECAL_LSB +: $bits(recal_t)];
      exp_fail[(e + 1) & 7]  = (ff != NUM_LANES);
      exp_ack[(e + 2) & 7]   = sum;  // ACK total one stage later
      last_sched = e + 2;
      md_short = f[LANE3_BASE + SFN_BIT];
    end
  endtask

  task automatic send_idle();
    @(negedge rx_clk_in);
    valid_in = 1'b0;
    flit_in  = long_flit(1'b0);  // Junk on the bus while idle
  endtask

  task automatic drain_pipeline();
    int n;
    n = 0;
    do begin
      @(negedge rx_clk_in);
      valid_in = 1'b0;
      #1;  // Past the monitor's update
      n++;
      if (n > 40) begin
        abort_run($sformatf("Timeout in %s, results or error did not settle", test_name));
      end
    end while (cyc <= last_sched + 1 || err_prev);
  endtask

  task automatic wait_forced_valid();
    int n;
    n = 0;
    while (forced_valid_out !== 1'b1) begin
      @(negedge rx_clk_in);
      valid_in = 1'b0;
      n++;
      if (n > 10) begin
        abort_run($sformatf("Timeout in %s waiting for forced_valid_out", test_name));
      end
    end
  endtask

  // Output monitor, one check of every output per cycle
  always @(negedge rx_clk_in) begin
    int s;
    bit err_now;
    bit v_exp;
    bit fv_exp;
    if (mon_on) begin
      s       = cyc & 7;
      err_now = exp_fail[s] | (err_prev & ~vout_prev);  // Sticky until a valid_out
      v_exp   = exp_long[s] | exp_force[s];
      fv_exp  = exp_force[s] & ~exp_long[s];
      if (exp_long[s]) begin
        flit_hold  = exp_flit[s];
        flit_known = 1'b1;
      end
      compare_value("valid_out", v_exp, valid_out);
      compare_value("forced_valid_out", fv_exp, forced_valid_out);
      compare_value("sf_crc_error", err_now, sf_crc_error);
      compare_value("sf_ack_cnt", exp_ack[s], sf_ack_cnt);
      compare_value("sf_recal_status", exp_recal[s], sf_recal_status);
      if (flit_known) begin
        compare_value("flit_out", flit_hold, flit_out);
      end
      if (err_now && !err_prev) begin
        exp_force[(cyc + 1) & 7] = 1'b1;  // Pulse follows the error rise
      end
      err_prev     = err_now;
      vout_prev    = v_exp;
      exp_long[s]  = 1'b0;
      exp_fail[s]  = 1'b0;
      exp_force[s] = 1'b0;
      exp_ack[s]   = '0;
      exp_recal[s] = '0;
      if (DUT.u_asserts.fail_cnt != 0) begin
        abort_run($sformatf("Bound assertion failed during %s", test_name));
      end
    end
  end

  initial begin
    void'($urandom(32'hc304));
    reset    = 1'b1;
    valid_in = 1'b0;
    flit_in  = '0;
    for (int i = 0; i < 8; i++) begin
      exp_long[i]  = 1'b0;
      exp_flit[i]  = '0;
      exp_fail[i]  = 1'b0;
      exp_force[i] = 1'b0;
      exp_ack[i]   = '0;
      exp_recal[i] = '0;
    end
    repeat (5) @(negedge rx_clk_in);
    reset  = 1'b0;
    mon_on = 1'b1;

    test_name = "long_random";  // Run lengths 0..15, SFN clear
    for (int i = 0; i < 40; i++) begin
      if ($urandom_range(3) == 0) begin
        send_idle();
      end
      send_flit(long_flit(1'b0), '1);
    end
    while (rl_left > 0) begin
      send_flit(long_flit(1'b0), '1);
    end
    drain_pipeline();

    test_name = "short_good";
    send_flit(control_flit(4'd0, 1'b1), '1);
    send_flit(short_flit(1'b0, -1), '1);
    drain_pipeline();

    test_name = "short_chain";  // Run length 12 also means no data
    send_flit(control_flit(4'd12, 1'b1), '1);
    for (int i = 0; i < 3; i++) begin
      send_flit(short_flit(i < 2, -1), '1);
    end
    repeat (3) send_flit(long_flit(1'b0), '1);
    while (rl_left > 0) begin
      send_flit(long_flit(1'b0), '1);
    end
    drain_pipeline();

    test_name = "crc_error";
    send_flit(control_flit(4'd0, 1'b1), '1);
    send_flit(short_flit(1'b0, 2), lane_mask(2));
    wait_forced_valid();
    drain_pipeline();

    test_name = "lane1_corrupt";  // Recal from lane 0, lanes 0, 2, 3 in the ACK sum
    send_flit(control_flit(4'd0, 1'b1), '1);
    send_flit(short_flit(1'b0, 1), lane_mask(1));
    drain_pipeline();

    if (DUT.u_asserts.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("Bound assertion failed at the end of the run");
    end
  end

endmodule : tb_rx_short_flit

`default_nettype wire

// ==== tb.f ====
design/dlx_flit_pkg.sv
design/dlx_rx_ctl_pkg.sv
design/lane_crc_check.sv
design/flit_tracker.sv
design/short_flit_checker.sv
design/flit_output_stage.sv
design/rx_short_flit_top.sv
tests/rx_short_flit_asserts.sv
tests/tb_rx_short_flit.sv

// ==== Bender.yml ====
package:
  name: rx_short_flit

sources:
  # Design, packages first
  - files:
      - design/dlx_flit_pkg.sv
      - design/dlx_rx_ctl_pkg.sv
      - design/lane_crc_check.sv
      - design/flit_tracker.sv
      - design/short_flit_checker.sv
      - design/flit_output_stage.sv
      - design/rx_short_flit_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/rx_short_flit_asserts.sv
      - tests/tb_rx_short_flit.sv
